// File: Makefile
SIM      := verilator
FLAGS    := --binary --assert --timing -Wno-fatal -j 0
TOP      := board_inputs_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hw/board_pkg.sv
hw/input_sync_if.sv
hw/input_decode.sv
hw/board_control.sv
hw/input_format.sv
hw/board_inputs.sv
tb/board_inputs_tb.sv

// File: hw/board_control.sv
////////////////////////////////////////
// Board control: pause toggle, graphics
// layer enables and game reset stretcher
////////////////////////////////////////

module board_control
    import board_pkg::*;
(
    input  logic               clk_sys,
    input  logic               rst,
    input  logic               pause_evt,
    input  logic               soft_rst_evt,
    input  logic [NUM_GFX-1:0] gfx_evt,
    input  logic               dl_sync,
    input  logic               rst_req_sync,
    output logic               game_pause,
    output logic [NUM_GFX-1:0] gfx_en,
    output logic               game_rst
);

    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 rst_trig;

    // pause state
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
        end else if (dl_sync) begin
            game_pause <= 1'b0;  // never paused while loading
        end else if (pause_evt) begin
            game_pause <= ~game_pause;
        end
    end

    // layer enables, all visible out of reset
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            gfx_en <= '1;
        end else begin
            gfx_en <= gfx_en ^ gfx_evt;
        end
    end

    assign rst_trig = rst | rst_req_sync | dl_sync | soft_rst_evt;

    // hold game_rst until the count runs out after the last trigger
    always_ff @(posedge clk_sys) begin
        if (rst_trig) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != GAME_RST_LEN) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;
        end
    end

    // a layer bit flips only after its own key event
    a_gfx_cause: assert property (@(posedge clk_sys) disable iff (rst)
        ((gfx_en ^ $past(gfx_en)) & ~$past(gfx_evt)) == '0);

    // reset output covers the whole count
    a_rst_hold: assert property (@(posedge clk_sys) disable iff (rst)
        (rst_cnt < GAME_RST_LEN) |-> game_rst);

endmodule

// File: hw/board_inputs.sv
////////////////////////////////////////
// Board inputs top: player input sampling,
// game input formatting and game control
////////////////////////////////////////

module board_inputs
    import board_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   rst_req,
    input  logic                   downloading,
    input  logic                   osd_pause,
    input  logic                   rot_control,
    input  logic                   key_service,
    input  logic                   key_reset,
    input  logic                   key_pause,
    input  board_joy_t             board_joystick1,
    input  board_joy_t             board_joystick2,
    input  board_joy_t             board_joystick3,
    input  board_joy_t             board_joystick4,
    input  game_joy_t              key_joy1,
    input  game_joy_t              key_joy2,
    input  game_joy_t              key_joy3,
    input  logic [NUM_PLAYERS-1:0] key_coin,
    input  logic [NUM_PLAYERS-1:0] key_start,
    input  logic [NUM_GFX-1:0]     key_gfx,
    output game_joy_t              game_joystick1,
    output game_joy_t              game_joystick2,
    output game_joy_t              game_joystick3,
    output game_joy_t              game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service,
    output logic                   game_pause,
    output logic                   game_rst,
    output logic [NUM_GFX-1:0]     gfx_en
);

    logic               pause_evt, soft_rst_evt;
    logic [NUM_GFX-1:0] gfx_evt;
    logic               dl_sync, rst_req_sync;

    input_sync_if u_sync ();

    input_decode u_decode (
        .clk_sys, .rst,
        .board_joystick1, .board_joystick2, .board_joystick3, .board_joystick4,
        .key_joy1, .key_joy2, .key_joy3,
        .key_coin, .key_start, .key_service, .key_reset, .key_pause, .key_gfx,
        .osd_pause, .rot_control, .downloading, .rst_req,
        .sync         ( u_sync.decode ),
        .pause_evt, .soft_rst_evt, .gfx_evt, .dl_sync, .rst_req_sync
    );

    board_control u_control (
        .clk_sys, .rst,
        .pause_evt, .soft_rst_evt, .gfx_evt, .dl_sync, .rst_req_sync,
        .game_pause, .gfx_en, .game_rst
    );

    input_format u_format (
        .clk_sys, .rst,
        .sync         ( u_sync.format ),
        .game_joystick1, .game_joystick2, .game_joystick3, .game_joystick4,
        .game_coin, .game_start, .game_service
    );

endmodule

// File: hw/board_pkg.sv
////////////////////////////////////////
// Board package: shared widths, button
// positions, reset length and joystick types
////////////////////////////////////////

package board_pkg;

    // player counts
    localparam int NUM_PLAYERS     = 4;
    localparam int NUM_KEY_PLAYERS = 3;  // player 4 has no keyboard joystick

    // joystick word widths
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;

    // buttons used by the game
    localparam int BUTTONS = 2;

    // start, coin and pause follow the game buttons in a board joystick
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    // game expects low-true inputs
    localparam logic INPUTS_ACTIVE_LOW = 1'b1;

    // game reset stretch
    localparam int         RST_CNT_W    = 8;
    localparam logic [7:0] GAME_RST_LEN = 8'd255;  // cycles after last trigger

    // graphics layers that can be switched off
    localparam int NUM_GFX = 4;

    // one joystick as it comes from the board
    typedef logic [BOARD_JOY_W-1:0] board_joy_t;

    // one joystick as the game sees it
    // bits 3:0 are directions, upper bits are buttons
    typedef logic [GAME_JOY_W-1:0] game_joy_t;

endpackage

// File: hw/input_decode.sv
////////////////////////////////////////
// Input sampler: registers every board and
// key input, makes rising-edge event pulses
////////////////////////////////////////

module input_decode
    import board_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst,
    input  board_joy_t             board_joystick1,
    input  board_joy_t             board_joystick2,
    input  board_joy_t             board_joystick3,
    input  board_joy_t             board_joystick4,
    input  game_joy_t              key_joy1,
    input  game_joy_t              key_joy2,
    input  game_joy_t              key_joy3,
    input  logic [NUM_PLAYERS-1:0] key_coin,
    input  logic [NUM_PLAYERS-1:0] key_start,
    input  logic                   key_service,
    input  logic                   key_reset,
    input  logic                   key_pause,
    input  logic [NUM_GFX-1:0]     key_gfx,
    input  logic                   osd_pause,
    input  logic                   rot_control,
    input  logic                   downloading,
    input  logic                   rst_req,
    input_sync_if.decode           sync,
    output logic                   pause_evt,
    output logic                   soft_rst_evt,
    output logic [NUM_GFX-1:0]     gfx_evt,
    output logic                   dl_sync,
    output logic                   rst_req_sync
);

    logic               key_pause_q, osd_pause_q, key_reset_q;
    logic [NUM_GFX-1:0] key_gfx_q;
    logic               key_pause_l, osd_pause_l, joy_pause_l, key_reset_l;
    logic [NUM_GFX-1:0] key_gfx_l;
    logic               joy_pause;
    logic [2:0]         pause_edges;

    // first copy of every input, taken at edge N
    always_ff @(posedge clk_sys) begin
        sync.board_joy[0] <= board_joystick1;
        sync.board_joy[1] <= board_joystick2;
        sync.board_joy[2] <= board_joystick3;
        sync.board_joy[3] <= board_joystick4;
        sync.key_joy[0]   <= key_joy1;
        sync.key_joy[1]   <= key_joy2;
        sync.key_joy[2]   <= key_joy3;
        sync.key_coin     <= key_coin;
        sync.key_start    <= key_start;
        sync.key_service  <= key_service;
        sync.rot_control  <= rot_control;
        key_pause_q       <= key_pause;
        osd_pause_q       <= osd_pause;
        key_reset_q       <= key_reset;
        key_gfx_q         <= key_gfx;
        dl_sync           <= downloading;
        rst_req_sync      <= rst_req;
    end

    // pause button on either of the first two joysticks
    assign joy_pause = sync.board_joy[0][PAUSE_BIT] | sync.board_joy[1][PAUSE_BIT];

    // second copy at edge N+1, only for edge sources
    always_ff @(posedge clk_sys) begin
        key_pause_l <= key_pause_q;
        osd_pause_l <= osd_pause_q;
        joy_pause_l <= joy_pause;
        key_reset_l <= key_reset_q;
        key_gfx_l   <= key_gfx_q;
    end

    assign pause_edges  = {key_pause_q & ~key_pause_l,
                           osd_pause_q & ~osd_pause_l,
                           joy_pause   & ~joy_pause_l};
    assign pause_evt    = |pause_edges;
    assign soft_rst_evt = key_reset_q & ~key_reset_l;
    assign gfx_evt      = key_gfx_q & ~key_gfx_l;  // one pulse per layer key

    // no single source produces an event two cycles in a row
    a_evt_single: assert property (@(posedge clk_sys) disable iff (rst)
        ({pause_edges, soft_rst_evt} & $past({pause_edges, soft_rst_evt})) == '0);

endmodule

// File: hw/input_format.sv
////////////////////////////////////////
// Game input formatter: merge, rotate and
// invert joysticks, pack coin and start
////////////////////////////////////////

module input_format
    import board_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst,
    input_sync_if.format           sync,
    output game_joy_t              game_joystick1,
    output game_joy_t              game_joystick2,
    output game_joy_t              game_joystick3,
    output game_joy_t              game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service
);

    game_joy_t              merged [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] coin_raw;
    logic [NUM_PLAYERS-1:0] start_raw;

    // directions swapped for a rotated screen, then inverted
    function automatic game_joy_t format_joy(game_joy_t joy, logic rot);
        game_joy_t rj;
        rj = rot ? {joy[GAME_JOY_W-1:4], joy[0], joy[1], joy[3], joy[2]} : joy;
        return rj ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        if (p < NUM_KEY_PLAYERS) begin : g_key
            assign merged[p] = sync.board_joy[p][GAME_JOY_W-1:0] | sync.key_joy[p];
        end else begin : g_board
            assign merged[p] = sync.board_joy[p][GAME_JOY_W-1:0];  // board only
        end
        assign coin_raw[p]  = sync.board_joy[p][COIN_BIT]  | sync.key_coin[p];
        assign start_raw[p] = sync.board_joy[p][START_BIT] | sync.key_start[p];
    end

    // game inputs, registered at edge N+1
    always_ff @(posedge clk_sys) begin
        game_joystick1 <= format_joy(merged[0], sync.rot_control);
        game_joystick2 <= format_joy(merged[1], sync.rot_control);
        game_joystick3 <= format_joy(merged[2], sync.rot_control);
        game_joystick4 <= format_joy(merged[3], sync.rot_control);
        game_coin      <= coin_raw  ^ {NUM_PLAYERS{INPUTS_ACTIVE_LOW}};
        game_start     <= start_raw ^ {NUM_PLAYERS{INPUTS_ACTIVE_LOW}};
    end

    // service switch idles released
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_service <= INPUTS_ACTIVE_LOW;
        end else begin
            game_service <= sync.key_service ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

// File: hw/input_sync_if.sv
////////////////////////////////////////
// Sampled input bundle between the input
// sampler and the game input formatter
////////////////////////////////////////

interface input_sync_if
    import board_pkg::*;
();

    // registered copies, valid every cycle
    board_joy_t             board_joy [NUM_PLAYERS];
    game_joy_t              key_joy   [NUM_KEY_PLAYERS];
    logic [NUM_PLAYERS-1:0] key_coin;
    logic [NUM_PLAYERS-1:0] key_start;
    logic                   key_service;
    logic                   rot_control;  // vertical game on horizontal screen

    modport decode (
        output board_joy,
        output key_joy,
        output key_coin,
        output key_start,
        output key_service,
        output rot_control
    );

    modport format (
        input board_joy,
        input key_joy,
        input key_coin,
        input key_start,
        input key_service,
        input rot_control
    );

endinterface

// File: tb/board_inputs_tb.sv
////////////////////////////////////////
// Board inputs testbench: random stimulus,
// reference model and concurrent checks
////////////////////////////////////////

module board_inputs_tb
    import board_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 3;
    localparam int NUM_CYCLES = 3000;
    localparam int WATCHDOG   = (RST_CYCLES + NUM_CYCLES + 300) * CLK_PERIOD;

    // one snapshot of every DUT input that the checks need
    typedef struct packed {
        board_joy_t [NUM_PLAYERS-1:0] bj;
        game_joy_t  [NUM_PLAYERS-1:0] kj;  // player 4 tied to zero
        logic [NUM_PLAYERS-1:0]       coin;
        logic [NUM_PLAYERS-1:0]       start;
        logic                         service;
        logic                         rot;
        logic                         kpause;
        logic                         opause;
        logic                         kreset;
        logic [NUM_GFX-1:0]           gfx;
        logic                         dl;
        logic                         rreq;
    } in_t;

    logic clk_sys, rst, rst_req, downloading, osd_pause, rot_control;
    logic key_service, key_reset, key_pause;
    board_joy_t board_joystick1, board_joystick2, board_joystick3, board_joystick4;
    game_joy_t  key_joy1, key_joy2, key_joy3;
    logic [NUM_PLAYERS-1:0] key_coin, key_start, game_coin, game_start;
    logic [NUM_GFX-1:0]     key_gfx, gfx_en;
    game_joy_t  game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic       game_service, game_pause, game_rst;

    in_t                    now_in, s1, s2;
    game_joy_t              got_joy [NUM_PLAYERS];
    game_joy_t              exp_joy [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] exp_coin, exp_start;
    logic                   pause_rise, reset_rise, trig, ref_pause, exp_rst;
    logic [NUM_GFX-1:0]     gfx_rise, ref_gfx;
    logic [15:0]            since_trig;  // edges since the last reset trigger
    logic [3:0]             cyc = '0;
    logic                   warm;
    int                     dl_left;

    board_inputs UUT (.*);

    function automatic game_joy_t expect_joy(input board_joy_t bj, input game_joy_t kj,
                                             input logic rot);
        game_joy_t m;
        game_joy_t r;
        m = bj[GAME_JOY_W-1:0] | kj;
        r = m;
        if (rot) begin  // rotated screen swaps the directions
            r[3] = m[0];
            r[2] = m[1];
            r[1] = m[3];
            r[0] = m[2];
        end
        return INPUTS_ACTIVE_LOW ? ~r : r;
    endfunction

    function automatic logic joy_pause_of(input in_t x);
        return x.bj[0][PAUSE_BIT] | x.bj[1][PAUSE_BIT];
    endfunction

    function automatic logic rare(input int unsigned n);
        return ($urandom % n) == 0;
    endfunction

    function automatic board_joy_t rand_board_joy(input logic pause_pin);
        board_joy_t j;
        j = board_joy_t'($urandom);
        j[PAUSE_BIT] = pause_pin;
        return j;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] t=%0t %s got=%h expected=%h", $time, name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "value check failed");
    endtask

    assign now_in = '{bj: {board_joystick4, board_joystick3, board_joystick2, board_joystick1},
                      kj: {GAME_JOY_W'(0), key_joy3, key_joy2, key_joy1},
                      coin: key_coin, start: key_start, service: key_service,
                      rot: rot_control, kpause: key_pause, opause: osd_pause,
                      kreset: key_reset, gfx: key_gfx, dl: downloading, rreq: rst_req};
    assign got_joy = '{game_joystick1, game_joystick2, game_joystick3, game_joystick4};

    always_comb begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            exp_joy[p]   = expect_joy(s2.bj[p], s2.kj[p], s2.rot);
            exp_coin[p]  = (s2.bj[p][COIN_BIT] | s2.coin[p]) ^ INPUTS_ACTIVE_LOW;
            exp_start[p] = (s2.bj[p][START_BIT] | s2.start[p]) ^ INPUTS_ACTIVE_LOW;
        end
    end

    // rising edges as the DUT sees them one edge after sampling
    assign pause_rise = (s1.kpause & ~s2.kpause) | (s1.opause & ~s2.opause)
                      | (joy_pause_of(s1) & ~joy_pause_of(s2));
    assign reset_rise = s1.kreset & ~s2.kreset;
    assign gfx_rise   = s1.gfx & ~s2.gfx;
    assign trig       = rst | s1.rreq | s1.dl | reset_rise;
    assign exp_rst    = since_trig <= 16'(GAME_RST_LEN);
    assign warm       = cyc >= 4'd3;

    always @(posedge clk_sys) begin
        s1 <= now_in;
        s2 <= s1;
        if (cyc != 4'hf) cyc <= cyc + 4'd1;
        if (rst) begin
            ref_pause <= 1'b0;
            ref_gfx   <= '1;
        end else begin
            if (s1.dl) ref_pause <= 1'b0;
            else if (pause_rise) ref_pause <= ~ref_pause;
            ref_gfx <= ref_gfx ^ gfx_rise;
        end
        if (trig) since_trig <= '0;
        else if (since_trig != '1) since_trig <= since_trig + 16'd1;
    end

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_joy_chk
        a_joy: assert property (@(posedge clk_sys) disable iff (!warm) got_joy[p] == exp_joy[p])
            else report_mismatch($sformatf("game_joystick%0d", p + 1),
                                 32'(got_joy[p]), 32'(exp_joy[p]));
    end

    a_coin: assert property (@(posedge clk_sys) disable iff (!warm) game_coin == exp_coin)
        else report_mismatch("game_coin", 32'(game_coin), 32'(exp_coin));
    a_start: assert property (@(posedge clk_sys) disable iff (!warm) game_start == exp_start)
        else report_mismatch("game_start", 32'(game_start), 32'(exp_start));
    a_service: assert property (@(posedge clk_sys) disable iff (!warm)
        game_service == (s2.service ^ INPUTS_ACTIVE_LOW))
        else report_mismatch("game_service", 32'(game_service),
                             32'(s2.service ^ INPUTS_ACTIVE_LOW));
    a_pause: assert property (@(posedge clk_sys) disable iff (rst) game_pause == ref_pause)
        else report_mismatch("game_pause", 32'(game_pause), 32'(ref_pause));
    a_gfx: assert property (@(posedge clk_sys) disable iff (rst) gfx_en == ref_gfx)
        else report_mismatch("gfx_en", 32'(gfx_en), 32'(ref_gfx));
    a_rst: assert property (@(posedge clk_sys) disable iff (rst) game_rst == exp_rst)
        else report_mismatch("game_rst", 32'(game_rst), 32'(exp_rst));
    a_dl_pause: assert property (@(posedge clk_sys) disable iff (rst) $past(s1.dl) |-> !game_pause)
        else report_mismatch("game_pause", 32'(game_pause), 32'd0);
    a_key_rst: assert property (@(posedge clk_sys) disable iff (rst) $past(reset_rise) |-> game_rst)
        else report_mismatch("game_rst", 32'(game_rst), 32'd1);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog timeout, the stimulus did not finish in time");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'hfbfa_e0b8));
        {rst, rst_req, downloading, osd_pause, rot_control} = 5'b10000;
        {key_service, key_reset, key_pause, key_coin, key_start, key_gfx} = '0;
        {board_joystick1, board_joystick2, board_joystick3, board_joystick4} = '0;
        {key_joy1, key_joy2, key_joy3} = '0;
        dl_left = 0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        rst <= 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk_sys);
            board_joystick1 <= rand_board_joy(rare(40));
            board_joystick2 <= rand_board_joy(rare(40));
            board_joystick3 <= board_joy_t'($urandom);
            board_joystick4 <= board_joy_t'($urandom);
            key_joy1        <= game_joy_t'($urandom);
            key_joy2        <= game_joy_t'($urandom);
            key_joy3        <= game_joy_t'($urandom);
            {key_coin, key_start} <= 8'($urandom);
            key_service     <= 1'($urandom);
            rot_control     <= 1'($urandom);
            osd_pause       <= rare(50);
            key_pause       <= rare(50);
            key_reset       <= rare(400);
            key_gfx         <= {rare(30), rare(30), rare(30), rare(30)};
            rst_req         <= rare(900);
            if (dl_left > 0) dl_left = dl_left - 1;  // short download bursts
            else if (rare(700)) dl_left = 10 + int'($urandom % 20);
            downloading     <= dl_left > 0;
        end
        repeat (4) @(posedge clk_sys);
        $display("=== PASS ===");
        $finish;
    end

endmodule
